//--- Makefile
SIM_LOG = sim.log

.PHONY: all lint clean

all: obj_dir/Vtb_apu_dmc
	./obj_dir/Vtb_apu_dmc | tee $(SIM_LOG)
	grep -q "=== PASS ===" $(SIM_LOG)

obj_dir/Vtb_apu_dmc: sources.f hdl/*.sv tb/*.sv
	verilator --binary --timing --assert -Wno-fatal --top-module tb_apu_dmc -f sources.f

lint:
	verilator --lint-only -Wall -Wno-fatal --top-module apu_dmc \
	  hdl/apu_pkg.sv hdl/apu_divider.sv hdl/dmc_reg_file.sv \
	  hdl/dmc_reader.sv hdl/dmc_output_unit.sv hdl/apu_dmc.sv

clean:
	rm -rf obj_dir $(SIM_LOG)

//--- hdl/apu_divider.sv
`default_nettype none

module apu_divider #(
  parameter int WIDTH = 9
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             clk_en,
  input  logic [WIDTH-1:0] period,
  output logic             pulse
);

  logic [WIDTH-1:0] count;

  // count of zero fires the pulse and reloads, so a pulse comes every period steps
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (clk_en) begin
      if (count == '0) begin
        count <= period - 1'b1;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  assign pulse = clk_en && (count == '0);   // first pulse right after reset

endmodule

`default_nettype wire

//--- hdl/apu_dmc.sv
`default_nettype none

module apu_dmc #(
  parameter int TIMER_W = 9
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cpu_clk_en,
  input  apu_pkg::reg_write_t         reg_wr,
  output logic                        mem_req,
  output logic [apu_pkg::ADDR_W-1:0]  mem_addr,
  input  logic                        mem_ack,
  input  logic [7:0]                  mem_data,
  output logic                        irq,
  output logic [apu_pkg::LEVEL_W-1:0] level
);

  apu_pkg::dmc_cfg_t           cfg;
  logic [TIMER_W-1:0]          timer_period;
  logic                        direct_load;
  logic [apu_pkg::LEVEL_W-1:0] direct_level;
  logic                        irq_ack;
  logic                        restart;
  logic                        idle;
  logic                        tick;
  logic                        buf_full;
  logic [7:0]                  buf_data;
  logic                        buf_take;

  dmc_reg_file #(.TIMER_W(TIMER_W)) regs (
    .clk, .rst_n, .cpu_clk_en, .reg_wr, .idle, .cfg, .timer_period,
    .direct_load, .direct_level, .irq_ack, .restart
  );

  apu_divider #(.WIDTH(TIMER_W)) rate_timer (
    .clk, .rst_n, .clk_en(cpu_clk_en), .period(timer_period), .pulse(tick)
  );

  dmc_reader reader (
    .clk, .rst_n, .cpu_clk_en, .cfg, .irq_ack, .restart, .buf_take, .mem_ack,
    .mem_data, .mem_req, .mem_addr, .buf_full, .buf_data, .irq, .idle
  );

  dmc_output_unit out_unit (
    .clk, .rst_n, .cpu_clk_en, .tick, .buf_full, .buf_data, .direct_load,
    .direct_level, .buf_take, .level
  );

endmodule

`default_nettype wire

//--- hdl/apu_pkg.sv
`default_nettype none

package apu_pkg;

  // *************************************************************************
  // register port
  // *************************************************************************

  typedef enum logic [2:0] {
    ctrl   = 3'd0,                          // irq enable, loop and rate index
    direct = 3'd1,                          // direct-load level
    addr   = 3'd2,                          // sample address byte
    length = 3'd3,                          // sample length byte
    status = 3'd4                           // bit 4 enables the channel
  } reg_addr_e;

  typedef struct packed {
    logic       irq_enable;
    logic       loop;
    logic [1:0] gap;
    logic [3:0] rate_index;
  } ctrl_view_t;

  typedef struct packed {
    logic       spare;
    logic [6:0] level;
  } level_view_t;

  // the same write byte is read as control fields or as a load level
  typedef union packed {
    ctrl_view_t  ctl_view;
    level_view_t lvl_view;
  } reg_data_u;

  typedef struct packed {
    logic      wr;
    reg_addr_e addr;
    reg_data_u data;
  } reg_write_t;

  // *************************************************************************
  // channel settings
  // *************************************************************************

  typedef struct packed {
    logic       irq_enable;
    logic       loop;
    logic       enable;
    logic [7:0] sample_addr;
    logic [7:0] sample_len;
  } dmc_cfg_t;

  // timer periods in enabled clocks, index 0 is the slowest rate
  localparam logic [0:15][8:0] rate_table = {
    9'd428, 9'd380, 9'd340, 9'd320,
    9'd286, 9'd254, 9'd226, 9'd214,
    9'd190, 9'd160, 9'd142, 9'd128,
    9'd106, 9'd84,  9'd72,  9'd54
  };

  localparam logic [15:0] SAMPLE_BASE = 16'hC000;
  localparam logic [15:0] WRAP_ADDR   = 16'h8000;   // fetches past 0xFFFF continue here
  localparam int          ADDR_W      = 15;         // bit 15 of the bus is always set
  localparam int          LEVEL_W     = 7;

endpackage

`default_nettype wire

//--- hdl/dmc_output_unit.sv
`default_nettype none

module dmc_output_unit (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cpu_clk_en,
  input  logic                        tick,
  input  logic                        buf_full,
  input  logic [7:0]                  buf_data,
  input  logic                        direct_load,
  input  logic [apu_pkg::LEVEL_W-1:0] direct_level,
  output logic                        buf_take,
  output logic [apu_pkg::LEVEL_W-1:0] level
);

  logic                        new_cycle;
  logic                        silence;
  logic [7:0]                  shift_data;
  logic [apu_pkg::LEVEL_W-1:0] next_level;

  // eight ticks make one output cycle
  apu_divider #(
    .WIDTH (4)
  ) bit_counter (
    .clk    (clk),
    .rst_n  (rst_n),
    .clk_en (tick),
    .period (4'd8),
    .pulse  (new_cycle)
  );

  assign buf_take = new_cycle && buf_full;

  // *************************************************************************
  // shifter and silence flag
  // *************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      silence <= 1'b1;
    end else if (new_cycle) begin
      silence <= !buf_full;                  // an empty buffer mutes the whole cycle
    end
  end

  always_ff @(posedge clk) begin
    if (buf_take) begin
      shift_data <= buf_data;
    end else if (tick) begin
      shift_data <= shift_data >> 1;         // lsb first
    end
  end

  // *************************************************************************
  // level integrator
  // *************************************************************************

  always_comb begin
    next_level = level;
    if (tick && !silence) begin
      if (shift_data[0] && level <= 7'd125) begin
        next_level = level + 7'd2;
      end else if (!shift_data[0] && level >= 7'd2) begin
        next_level = level - 7'd2;
      end
    end
    if (direct_load) begin
      next_level = direct_level;             // wins over this cycle's step
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      level <= '0;
    end else if (cpu_clk_en) begin
      level <= next_level;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dmc_reader.sv
`default_nettype none

module dmc_reader (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       cpu_clk_en,
  input  apu_pkg::dmc_cfg_t          cfg,
  input  logic                       irq_ack,
  input  logic                       restart,
  input  logic                       buf_take,
  input  logic                       mem_ack,
  input  logic [7:0]                 mem_data,
  output logic                       mem_req,
  output logic [apu_pkg::ADDR_W-1:0] mem_addr,
  output logic                       buf_full,
  output logic [7:0]                 buf_data,
  output logic                       irq,
  output logic                       idle
);

  logic [apu_pkg::ADDR_W-1:0] start_addr;
  logic [apu_pkg::ADDR_W-1:0] cur_addr;
  logic [apu_pkg::ADDR_W-1:0] next_addr;
  logic [11:0]                start_len;
  logic [11:0]                bytes_left;
  logic                       fetch_start;
  logic                       fetch_done;
  logic                       last_byte;

  assign start_addr = apu_pkg::SAMPLE_BASE[apu_pkg::ADDR_W-1:0]
                    + {1'b0, cfg.sample_addr, 6'b0};
  assign start_len  = {cfg.sample_len, 4'b0001};
  assign next_addr  = (cur_addr == '1) ? apu_pkg::WRAP_ADDR[apu_pkg::ADDR_W-1:0]
                                       : cur_addr + 1'b1;

  assign idle        = (bytes_left == '0);
  assign fetch_start = !mem_req && !mem_ack && !buf_full && !idle;  // ack must be low first
  assign fetch_done  = mem_req && mem_ack;
  assign last_byte   = fetch_done && (bytes_left == 12'd1);

  // *************************************************************************
  // four-phase requester
  // *************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_req  <= 1'b0;
      mem_addr <= '0;
    end else if (cpu_clk_en) begin
      if (fetch_start) begin
        mem_req  <= 1'b1;
        mem_addr <= cur_addr;                // held apart from cur_addr while req is high
      end else if (fetch_done) begin
        mem_req  <= 1'b0;
      end
    end
  end

  // *************************************************************************
  // address and byte counters
  // *************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_addr   <= '0;
      bytes_left <= '0;
    end else if (cpu_clk_en) begin
      if (!cfg.enable) begin
        bytes_left <= '0;                    // a fetch in flight still lands in the buffer
      end else if (restart) begin
        cur_addr   <= start_addr;
        bytes_left <= start_len;
      end else if (fetch_done && !idle) begin
        if (last_byte && cfg.loop) begin
          cur_addr   <= start_addr;
          bytes_left <= start_len;
        end else begin
          cur_addr   <= next_addr;
          bytes_left <= bytes_left - 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq <= 1'b0;
    end else if (cpu_clk_en) begin
      if (irq_ack) begin
        irq <= 1'b0;
      end
      if (last_byte && cfg.enable && !cfg.loop && cfg.irq_enable) begin
        irq <= 1'b1;
      end
    end
  end

  // *************************************************************************
  // sample buffer
  // *************************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      buf_full <= 1'b0;
    end else if (cpu_clk_en) begin
      if (fetch_done) begin
        buf_full <= 1'b1;
      end else if (buf_take) begin
        buf_full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_clk_en && fetch_done) begin
      buf_data <= mem_data;
    end
  end

endmodule

`default_nettype wire

//--- hdl/dmc_reg_file.sv
`default_nettype none

module dmc_reg_file #(
  parameter int TIMER_W = 9
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        cpu_clk_en,
  input  apu_pkg::reg_write_t         reg_wr,
  input  logic                        idle,
  output apu_pkg::dmc_cfg_t           cfg,
  output logic [TIMER_W-1:0]          timer_period,
  output logic                        direct_load,
  output logic [apu_pkg::LEVEL_W-1:0] direct_level,
  output logic                        irq_ack,
  output logic                        restart
);

  logic [3:0] rate_index;
  logic [7:0] wr_byte;

  assign wr_byte = reg_wr.data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg         <= '0;
      rate_index  <= '0;
      direct_load <= 1'b0;
      irq_ack     <= 1'b0;
      restart     <= 1'b0;
    end else if (cpu_clk_en) begin
      direct_load <= 1'b0;
      irq_ack     <= 1'b0;
      restart     <= 1'b0;
      if (reg_wr.wr) begin
        case (reg_wr.addr)
          apu_pkg::ctrl: begin
            cfg.irq_enable <= reg_wr.data.ctl_view.irq_enable;
            cfg.loop       <= reg_wr.data.ctl_view.loop;
            rate_index     <= reg_wr.data.ctl_view.rate_index;
            irq_ack        <= 1'b1;             // any ctrl write clears a pending irq
          end
          apu_pkg::direct: direct_load <= 1'b1;
          apu_pkg::addr:   cfg.sample_addr <= wr_byte;
          apu_pkg::length: cfg.sample_len <= wr_byte;
          apu_pkg::status: begin
            cfg.enable <= wr_byte[4];
            restart    <= wr_byte[4] && idle;   // only an exhausted sample restarts
          end
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cpu_clk_en && reg_wr.wr && reg_wr.addr == apu_pkg::direct) begin
      direct_level <= reg_wr.data.lvl_view.level;
    end
  end

  assign timer_period = TIMER_W'(apu_pkg::rate_table[rate_index]);

endmodule

`default_nettype wire

//--- sources.f
hdl/apu_pkg.sv
hdl/apu_divider.sv
hdl/dmc_reg_file.sv
hdl/dmc_reader.sv
hdl/dmc_output_unit.sv
hdl/apu_dmc.sv
tb/tb_apu_dmc.sv

//--- tb/tb_apu_dmc.sv
`default_nettype none

module tb_apu_dmc;

  localparam int TICK_CYCLES     = 54;                     // timer period at rate index 15
  localparam int BYTE_CYCLES     = 8 * TICK_CYCLES;        // one sample byte per output cycle
  localparam int SAMPLE_BYTES    = 17 + 81 + 17 + 20;
  localparam int LEVEL_TICKS     = 40 + (33 + 16 + 30) + (63 + 16 + 30);
  localparam int RUN_CYCLES      = SAMPLE_BYTES * BYTE_CYCLES + LEVEL_TICKS * TICK_CYCLES;
  localparam int WATCHDOG_CYCLES = RUN_CYCLES + RUN_CYCLES / 2;

  logic                        clk;
  logic                        rst_n;
  logic                        cpu_clk_en;
  apu_pkg::reg_write_t         reg_wr;
  logic                        mem_req;
  logic [apu_pkg::ADDR_W-1:0]  mem_addr;
  logic                        mem_ack;
  logic [7:0]                  mem_data;
  logic                        irq;
  logic [apu_pkg::LEVEL_W-1:0] level;

  int unsigned lcg_state = 32'd54105;
  logic        fixed_mode;                                 // constant data instead of address
  logic [7:0]  fixed_byte;
  logic [7:0]  exp_areg;
  int          exp_total;
  int          exp_index;
  logic        exp_loop;
  logic [15:0] exp_addr;                                   // next address the reader must ask for
  int          reqs_left;
  int          done_count;

  logic irq_forbidden;
  logic level_up;
  logic level_down;
  logic level_hold;

  logic                        prev_req;
  logic                        prev_ack;
  logic [apu_pkg::ADDR_W-1:0]  prev_addr;
  logic [apu_pkg::LEVEL_W-1:0] prev_level;

  apu_dmc #(.TIMER_W(9)) UUT (
    .clk, .rst_n, .cpu_clk_en, .reg_wr, .mem_req, .mem_addr, .mem_ack, .mem_data,
    .irq, .level
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ***************************************************************************
  // helpers
  // ***************************************************************************

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // start plus offset, and past 0xFFFF the sample goes on from 0x8000
  function automatic logic [15:0] sample_addr_at(input logic [7:0] a, input int i);
    int full;
    full = 32'hC000 + 64 * int'(a) + i;
    if (full > 32'hFFFF) begin
      full = full - 32'h8000;
    end
    return full[15:0];
  endfunction

  task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR: %s expected 0x%0h, actual 0x%0h", name, expected, actual);
    stop_with_failure();
  endtask

  task automatic report_failure(input string what);
    $display("%s", what);
    stop_with_failure();
  endtask

  task automatic advance_expected();
    exp_index++;
    if (exp_index == exp_total && exp_loop) begin
      exp_index = 0;                                       // a looping sample starts over
    end
    exp_addr = sample_addr_at(exp_areg, exp_index);
    if (reqs_left > 0) begin
      reqs_left--;
    end
    done_count++;
  endtask

  task automatic write_reg(input apu_pkg::reg_addr_e a, input apu_pkg::reg_data_u d);
    reg_wr.wr   = 1'b1;
    reg_wr.addr = a;
    reg_wr.data = d;
    @(posedge clk);
    #1;
    reg_wr.wr   = 1'b0;
  endtask

  task automatic write_ctrl(input logic irq_en, input logic loop_en);
    apu_pkg::reg_data_u d;
    d                     = '0;
    d.ctl_view.irq_enable = irq_en;
    d.ctl_view.loop       = loop_en;
    d.ctl_view.rate_index = 4'hF;
    write_reg(apu_pkg::ctrl, d);
  endtask

  task automatic write_level(input logic [apu_pkg::LEVEL_W-1:0] v);
    apu_pkg::reg_data_u d;
    d                = '0;
    d.lvl_view.level = v;
    write_reg(apu_pkg::direct, d);
  endtask

  task automatic start_sample(input logic [7:0] a, input logic [7:0] l, input logic irq_en,
                              input logic loop_en, input int limit);
    exp_areg   = a;
    exp_total  = 16 * int'(l) + 1;
    exp_index  = 0;
    exp_loop   = loop_en;
    exp_addr   = sample_addr_at(a, 0);
    done_count = 0;
    reqs_left  = (limit > 0) ? limit : exp_total;
    write_reg(apu_pkg::addr, a);
    write_reg(apu_pkg::length, l);
    write_ctrl(irq_en, loop_en);
    write_reg(apu_pkg::status, 8'h10);
  endtask

  task automatic wait_sample_end();
    wait (reqs_left == 0);
    @(posedge clk);
    #1;
  endtask

  // one request may still rise in the two cycles before the clear reaches the counter
  task automatic stop_channel();
    write_reg(apu_pkg::status, 8'h00);
    repeat (2) @(posedge clk);
    #1;
    reqs_left = 0;
    wait (!mem_req && !mem_ack);
    repeat (2) @(posedge clk);
    #1;
  endtask

  initial begin : memory_model
    int unsigned wait_cycles;
    mem_ack  = 1'b0;
    mem_data = 8'h00;
    forever begin
      @(posedge clk);
      #1;
      if (mem_req) begin
        wait_cycles = next_random() % 6;
        repeat (wait_cycles) begin
          @(posedge clk);
          #1;
        end
        mem_ack  = 1'b1;
        mem_data = fixed_mode ? fixed_byte : mem_addr[7:0];
        do begin
          @(posedge clk);
          #1;
        end while (mem_req);
        @(posedge clk);                                    // ack falls one cycle after req
        #1;
        mem_ack = 1'b0;
        advance_expected();
      end
    end
  end

  // ***************************************************************************
  // checks
  // ***************************************************************************

  always @(posedge clk) begin
    prev_req   <= mem_req;
    prev_ack   <= mem_ack;
    prev_addr  <= mem_addr;
    prev_level <= level;
  end

  addr_held: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req && prev_req) |-> (mem_addr == prev_addr))
    else report_mismatch("mem_addr", 32'($sampled(prev_addr)), 32'($sampled(mem_addr)));

  req_after_ack: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req && !prev_req) |-> !prev_ack)
    else report_failure("mem_req rose while mem_ack was still high");

  fetch_due: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req && !prev_req) |-> (reqs_left > 0))
    else report_failure("memory request issued when no fetch was due");

  fetch_order: assert property (@(posedge clk) disable iff (!rst_n)
    (mem_req && !prev_req) |-> ({1'b1, mem_addr} == exp_addr))
    else report_mismatch("mem_addr", 32'($sampled(exp_addr)), 32'({1'b1, $sampled(mem_addr)}));

  irq_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    irq_forbidden |-> !irq)
    else report_mismatch("irq", 32'd0, 32'($sampled(irq)));

  level_rising: assert property (@(posedge clk) disable iff (!rst_n)
    (level_up && level != prev_level) |-> ({1'b0, level} == {1'b0, prev_level} + 8'd2))
    else report_mismatch("level", 32'($sampled(prev_level)) + 32'd2, 32'($sampled(level)));

  level_falling: assert property (@(posedge clk) disable iff (!rst_n)
    (level_down && level != prev_level) |-> ({1'b0, level} + 8'd2 == {1'b0, prev_level}))
    else report_mismatch("level", 32'($sampled(prev_level)) - 32'd2, 32'($sampled(level)));

  level_frozen: assert property (@(posedge clk) disable iff (!rst_n)
    level_hold |-> (level == prev_level))
    else report_mismatch("level", 32'($sampled(prev_level)), 32'($sampled(level)));

  initial begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_failure("timeout: the tests did not finish within the watchdog limit");
  end

  // ***************************************************************************
  // stimulus
  // ***************************************************************************

  initial begin : stimulus
    rst_n          = 1'b0;
    cpu_clk_en     = 1'b1;
    reg_wr         = '0;
    fixed_mode     = 1'b0;
    fixed_byte     = 8'h00;
    exp_areg       = 8'h00;
    exp_total      = 0;
    exp_index      = 0;
    exp_loop       = 1'b0;
    exp_addr       = 16'hC000;
    reqs_left      = 0;
    done_count     = 0;
    irq_forbidden  = 1'b0;
    level_up       = 1'b0;
    level_down     = 1'b0;
    level_hold     = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    assert (mem_req == 1'b0) else report_mismatch("mem_req", 32'd0, 32'(mem_req));
    assert (irq == 1'b0) else report_mismatch("irq", 32'd0, 32'(irq));
    assert (level == '0) else report_mismatch("level", 32'd0, 32'(level));
    repeat (40) @(posedge clk);                            // still disabled, so no fetch
    #1;

    start_sample(8'h10, 8'd1, 1'b1, 1'b0, 0);
    wait_sample_end();
    assert (irq == 1'b1) else report_mismatch("irq", 32'd1, 32'(irq));
    write_ctrl(1'b1, 1'b0);
    @(posedge clk);
    #1;
    assert (irq == 1'b0) else report_mismatch("irq", 32'd0, 32'(irq));

    start_sample(8'hFF, 8'd5, 1'b1, 1'b0, 0);              // 0xFFC0 upward crosses 0xFFFF
    wait_sample_end();
    assert (irq == 1'b1) else report_mismatch("irq", 32'd1, 32'(irq));
    write_ctrl(1'b0, 1'b0);
    @(posedge clk);
    #1;
    assert (irq == 1'b0) else report_mismatch("irq", 32'd0, 32'(irq));
    irq_forbidden = 1'b1;

    start_sample(8'h20, 8'd1, 1'b0, 1'b0, 0);
    wait_sample_end();
    repeat (20) @(posedge clk);
    #1;

    start_sample(8'h30, 8'd1, 1'b1, 1'b1, 1000);
    wait (done_count >= exp_total + 3);
    stop_channel();

    repeat (24 * TICK_CYCLES) @(posedge clk);              // drain the buffer into silence
    #1;
    write_level(7'd60);
    @(posedge clk);
    #1;
    assert (level == 7'd60) else report_mismatch("level", 32'd60, 32'(level));
    @(posedge clk);
    #1;
    level_hold = 1'b1;
    repeat (16 * TICK_CYCLES) @(posedge clk);
    #1;
    level_hold = 1'b0;

    fixed_mode = 1'b1;
    fixed_byte = 8'hFF;
    level_up   = 1'b1;
    start_sample(8'h40, 8'd1, 1'b0, 1'b1, 1000);
    wait (level == 7'd126);
    repeat (30 * TICK_CYCLES) @(posedge clk);
    #1;
    assert (level == 7'd126) else report_mismatch("level", 32'd126, 32'(level));
    stop_channel();

    level_up   = 1'b0;
    level_down = 1'b1;
    fixed_byte = 8'h00;
    start_sample(8'h50, 8'd1, 1'b0, 1'b1, 1000);
    wait (level == 7'd0);
    repeat (30 * TICK_CYCLES) @(posedge clk);
    #1;
    assert (level == 7'd0) else report_mismatch("level", 32'd0, 32'(level));
    stop_channel();
    level_down = 1'b0;

    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire
